// ==== exec_pkg.sv ====
package exec_pkg;

  // Datapath widths
  localparam int WORD_W = 32;
  localparam int STAT_W = 6;
  localparam int BYTE_W = 8;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [STAT_W-1:0] status_t;
  typedef logic [BYTE_W-1:0] byte_t;

  // Arithmetic flag positions inside status_t
  localparam int STAT_OF = 0;
  localparam int STAT_SF = 1;
  localparam int STAT_ZF = 2;
  localparam int STAT_PF = 3;
  localparam int STAT_CF = 4;
  localparam int STAT_AF = 5;

  // EFLAGS bit positions, also the AH layout for LAHF/SAHF
  localparam int EFLAGS_CF  = 0;
  localparam int EFLAGS_ONE = 1;
  localparam int EFLAGS_PF  = 2;
  localparam int EFLAGS_AF  = 4;
  localparam int EFLAGS_ZF  = 6;
  localparam int EFLAGS_SF  = 7;
  localparam int EFLAGS_DF  = 10;
  localparam int EFLAGS_OF  = 11;

  // Opcodes, anything not listed is illegal
  typedef enum logic [5:0] {
    CMD_NOP   = 6'd0,
    CMD_ADD   = 6'd1,
    CMD_ADC   = 6'd2,
    CMD_INC   = 6'd3,
    CMD_SUB   = 6'd4,
    CMD_SBB   = 6'd5,
    CMD_DEC   = 6'd6,
    CMD_CMP   = 6'd7,
    CMD_AND   = 6'd8,
    CMD_TEST  = 6'd9,
    CMD_OR    = 6'd10,
    CMD_XOR   = 6'd11,
    CMD_NOT   = 6'd12,
    CMD_MOV   = 6'd13,
    CMD_LEA   = 6'd14,
    CMD_MOVSX = 6'd15,
    CMD_MOVZX = 6'd16,
    CMD_XCHG  = 6'd17,
    CMD_STC   = 6'd18,
    CMD_CLC   = 6'd19,
    CMD_STD   = 6'd20,
    CMD_CLD   = 6'd21,
    CMD_LAHF  = 6'd22,
    CMD_SAHF  = 6'd23
  } cmd_e;

  // ALU core operation
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // Result source
  typedef enum logic [1:0] {
    UNIT_NONE = 2'd0,
    UNIT_ALU  = 2'd1,
    UNIT_MOVE = 2'd2,
    UNIT_META = 2'd3
  } unit_e;

endpackage

// ==== exec_ctrl_if.sv ====
interface exec_ctrl_if;

  // Unit select and ALU operation
  exec_pkg::unit_e   unit_sel;
  exec_pkg::alu_op_e alu_op;

  // Adder controls
  logic src_inv;
  logic use_carry;
  logic carry_in_one;

  // Flag handling
  logic keep_cf;
  logic no_flags;
  logic clear_cf_of;

  // Writeback and move extension
  logic no_wr;
  logic sext;
  logic zext;

  // Meta opcode, NOP unless a meta command
  exec_pkg::cmd_e meta_cmd;

  logic illegal;

  modport ctrl (
    output unit_sel, alu_op, src_inv, use_carry, carry_in_one, keep_cf,
           no_flags, clear_cf_of, no_wr, sext, zext, meta_cmd, illegal
  );

  modport unit (
    input unit_sel, alu_op, src_inv, use_carry, carry_in_one, keep_cf,
          no_flags, clear_cf_of, meta_cmd
  );

  modport commit (
    input unit_sel, no_wr, sext, zext, meta_cmd, illegal
  );

endinterface

// ==== exec_decode.sv ====
module exec_decode (
  input exec_pkg::cmd_e opc,
  exec_ctrl_if.ctrl     ctl
);

  always_comb begin
    // Defaults describe a NOP
    ctl.unit_sel     = exec_pkg::UNIT_NONE;
    ctl.alu_op       = exec_pkg::ALU_ADD;
    ctl.src_inv      = 1'b0;
    ctl.use_carry    = 1'b0;
    ctl.carry_in_one = 1'b0;
    ctl.keep_cf      = 1'b0;
    ctl.no_flags     = 1'b0;
    ctl.clear_cf_of  = 1'b0;
    ctl.no_wr        = 1'b0;
    ctl.sext         = 1'b0;
    ctl.zext         = 1'b0;
    ctl.meta_cmd     = exec_pkg::CMD_NOP;
    ctl.illegal      = 1'b0;

    case (opc)
      exec_pkg::CMD_NOP: ;

      // Add family
      exec_pkg::CMD_ADD,
      exec_pkg::CMD_ADC,
      exec_pkg::CMD_INC: begin
        ctl.unit_sel  = exec_pkg::UNIT_ALU;
        ctl.alu_op    = exec_pkg::ALU_ADD;
        ctl.use_carry = (opc == exec_pkg::CMD_ADC);
        // INC adds a constant one, CF untouched
        ctl.keep_cf   = (opc == exec_pkg::CMD_INC);
      end

      // Subtract family, a + ~b + 1
      exec_pkg::CMD_SUB,
      exec_pkg::CMD_SBB,
      exec_pkg::CMD_DEC,
      exec_pkg::CMD_CMP: begin
        ctl.unit_sel     = exec_pkg::UNIT_ALU;
        ctl.alu_op       = exec_pkg::ALU_SUB;
        ctl.src_inv      = 1'b1;
        // SBB takes the borrow from CF instead
        ctl.use_carry    = (opc == exec_pkg::CMD_SBB);
        // DEC needs the +1 too, or it would subtract two
        ctl.carry_in_one = (opc != exec_pkg::CMD_SBB);
        ctl.keep_cf      = (opc == exec_pkg::CMD_DEC);
        ctl.no_wr        = (opc == exec_pkg::CMD_CMP);
      end

      // Logic ops
      exec_pkg::CMD_AND,
      exec_pkg::CMD_TEST: begin
        ctl.unit_sel    = exec_pkg::UNIT_ALU;
        ctl.alu_op      = exec_pkg::ALU_AND;
        ctl.clear_cf_of = 1'b1;
        ctl.no_wr       = (opc == exec_pkg::CMD_TEST);
      end
      exec_pkg::CMD_OR: begin
        ctl.unit_sel    = exec_pkg::UNIT_ALU;
        ctl.alu_op      = exec_pkg::ALU_OR;
        ctl.clear_cf_of = 1'b1;
      end
      exec_pkg::CMD_XOR: begin
        ctl.unit_sel    = exec_pkg::UNIT_ALU;
        ctl.alu_op      = exec_pkg::ALU_XOR;
        ctl.clear_cf_of = 1'b1;
      end
      // NOT is XOR with all ones, flags untouched
      exec_pkg::CMD_NOT: begin
        ctl.unit_sel = exec_pkg::UNIT_ALU;
        ctl.alu_op   = exec_pkg::ALU_XOR;
        ctl.no_flags = 1'b1;
      end

      // Moves, LEA arrives already computed in opnd1
      exec_pkg::CMD_MOV,
      exec_pkg::CMD_LEA,
      exec_pkg::CMD_XCHG,
      exec_pkg::CMD_MOVSX,
      exec_pkg::CMD_MOVZX: begin
        ctl.unit_sel = exec_pkg::UNIT_MOVE;
        ctl.sext     = (opc == exec_pkg::CMD_MOVSX);
        ctl.zext     = (opc == exec_pkg::CMD_MOVZX);
      end

      // Direct flag and AH manipulation
      exec_pkg::CMD_STC,
      exec_pkg::CMD_CLC,
      exec_pkg::CMD_STD,
      exec_pkg::CMD_CLD,
      exec_pkg::CMD_LAHF,
      exec_pkg::CMD_SAHF: begin
        ctl.unit_sel = exec_pkg::UNIT_META;
        ctl.meta_cmd = opc;
      end

      default: ctl.illegal = 1'b1;
    endcase
  end

endmodule

// ==== exec_alu.sv ====
module exec_alu #(
  parameter int DATA_W = 32
) (
  exec_ctrl_if.unit          ctl,
  input  exec_pkg::status_t  status_in,
  input  logic [DATA_W-1:0]  opnd0,
  input  logic [DATA_W-1:0]  opnd1,
  output logic [DATA_W-1:0]  result,
  output exec_pkg::status_t  status_out
);

  logic [DATA_W-1:0] opnd_b;
  logic [DATA_W-1:0] addend;
  logic [DATA_W:0]   wide_sum;
  logic              carry_in;
  logic              is_sub;
  logic              is_arith;

  // Constant second operand
  // keep_cf marks INC/DEC (one), no_flags marks NOT (all ones)
  always_comb begin
    if (ctl.keep_cf) begin
      opnd_b = {{(DATA_W-1){1'b0}}, 1'b1};
    end else if (ctl.no_flags) begin
      opnd_b = '1;
    end else begin
      opnd_b = opnd1;
    end
  end

  assign is_sub   = (ctl.alu_op == exec_pkg::ALU_SUB);
  assign is_arith = is_sub || (ctl.alu_op == exec_pkg::ALU_ADD);

  // Shared adder
  assign addend = ctl.src_inv ? ~opnd_b : opnd_b;
  // Borrow is inverted carry when subtracting
  assign carry_in = ctl.use_carry ? (status_in[exec_pkg::STAT_CF] ^ ctl.src_inv)
                                  : ctl.carry_in_one;
  assign wide_sum = {1'b0, opnd0} + {1'b0, addend} + {{DATA_W{1'b0}}, carry_in};

  // Result select
  always_comb begin
    case (ctl.alu_op)
      exec_pkg::ALU_AND: result = opnd0 & opnd_b;
      exec_pkg::ALU_OR:  result = opnd0 | opnd_b;
      exec_pkg::ALU_XOR: result = opnd0 ^ opnd_b;
      default:           result = wide_sum[DATA_W-1:0];
    endcase
  end

  // Flag generation
  always_comb begin
    status_out = status_in;
    if (!ctl.no_flags) begin
      status_out[exec_pkg::STAT_ZF] = (result == '0);
      status_out[exec_pkg::STAT_SF] = result[DATA_W-1];
      // Even parity, low byte only
      status_out[exec_pkg::STAT_PF] = ~^result[7:0];

      if (is_arith) begin
        // Same-sign inputs, different-sign result
        status_out[exec_pkg::STAT_OF] = (opnd0[DATA_W-1] == addend[DATA_W-1]) &&
                                        (result[DATA_W-1] != opnd0[DATA_W-1]);
        status_out[exec_pkg::STAT_CF] = wide_sum[DATA_W] ^ is_sub;
        // Carry into bit 4, flipped back to a borrow for SUB
        status_out[exec_pkg::STAT_AF] = opnd0[4] ^ addend[4] ^ result[4] ^ is_sub;
      end

      if (ctl.clear_cf_of) begin
        status_out[exec_pkg::STAT_CF] = 1'b0;
        status_out[exec_pkg::STAT_OF] = 1'b0;
      end

      // INC/DEC
      if (ctl.keep_cf) begin
        status_out[exec_pkg::STAT_CF] = status_in[exec_pkg::STAT_CF];
      end
    end
  end

  // Known operands must give a known result
  always_comb begin
    if (ctl.unit_sel == exec_pkg::UNIT_ALU) begin
      assert (!$isunknown(result))
        else $error("ALU result unknown for op %0d", ctl.alu_op);
    end
  end

endmodule

// ==== exec_meta.sv ====
module exec_meta (
  exec_ctrl_if.unit          ctl,
  input  exec_pkg::status_t  status_in,
  input  logic               df_in,
  input  exec_pkg::byte_t    ah_in,
  output exec_pkg::byte_t    ah_out,
  output exec_pkg::status_t  status_out,
  output logic               df_out
);

  always_comb begin
    status_out = status_in;
    df_out     = df_in;
    ah_out     = ah_in;

    case (ctl.meta_cmd)
      // Carry and direction flags
      exec_pkg::CMD_STC: status_out[exec_pkg::STAT_CF] = 1'b1;
      exec_pkg::CMD_CLC: status_out[exec_pkg::STAT_CF] = 1'b0;
      exec_pkg::CMD_STD: df_out = 1'b1;
      exec_pkg::CMD_CLD: df_out = 1'b0;

      // AH takes the low EFLAGS byte layout
      exec_pkg::CMD_LAHF: begin
        ah_out                       = '0;
        ah_out[exec_pkg::EFLAGS_SF]  = status_in[exec_pkg::STAT_SF];
        ah_out[exec_pkg::EFLAGS_ZF]  = status_in[exec_pkg::STAT_ZF];
        ah_out[exec_pkg::EFLAGS_AF]  = status_in[exec_pkg::STAT_AF];
        ah_out[exec_pkg::EFLAGS_PF]  = status_in[exec_pkg::STAT_PF];
        ah_out[exec_pkg::EFLAGS_CF]  = status_in[exec_pkg::STAT_CF];
        // Bit 1 always reads as one
        ah_out[exec_pkg::EFLAGS_ONE] = 1'b1;
      end

      // Five flags back from AH, OF kept
      exec_pkg::CMD_SAHF: begin
        status_out[exec_pkg::STAT_SF] = ah_in[exec_pkg::EFLAGS_SF];
        status_out[exec_pkg::STAT_ZF] = ah_in[exec_pkg::EFLAGS_ZF];
        status_out[exec_pkg::STAT_AF] = ah_in[exec_pkg::EFLAGS_AF];
        status_out[exec_pkg::STAT_PF] = ah_in[exec_pkg::EFLAGS_PF];
        status_out[exec_pkg::STAT_CF] = ah_in[exec_pkg::EFLAGS_CF];
      end

      default: ;
    endcase
  end

endmodule

// ==== exec_commit.sv ====
module exec_commit #(
  parameter int DATA_W = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  exec_ctrl_if.commit        ctl,
  input  exec_pkg::word_t    eflags_in,
  input  logic [DATA_W-1:0]  opnd0,
  input  logic [DATA_W-1:0]  opnd1,
  input  logic [DATA_W-1:0]  alu_result,
  input  exec_pkg::status_t  alu_status,
  input  exec_pkg::byte_t    meta_ah,
  input  exec_pkg::status_t  meta_status,
  input  logic               meta_df,
  output logic               out_valid,
  output logic               wr_en,
  output logic               illegal,
  output logic [DATA_W-1:0]  result,
  output exec_pkg::word_t    eflags_out
);

  logic [DATA_W-1:0] move_val;
  logic [DATA_W-1:0] lahf_val;
  logic [DATA_W-1:0] result_d;
  logic              is_lahf;
  logic              wr_en_d;
  exec_pkg::word_t   eflags_d;

  // Status vector back into its EFLAGS positions
  function automatic exec_pkg::word_t merge_status(exec_pkg::word_t ef,
                                                   exec_pkg::status_t st);
    exec_pkg::word_t merged;
    merged = ef;
    merged[exec_pkg::EFLAGS_OF] = st[exec_pkg::STAT_OF];
    merged[exec_pkg::EFLAGS_SF] = st[exec_pkg::STAT_SF];
    merged[exec_pkg::EFLAGS_ZF] = st[exec_pkg::STAT_ZF];
    merged[exec_pkg::EFLAGS_AF] = st[exec_pkg::STAT_AF];
    merged[exec_pkg::EFLAGS_PF] = st[exec_pkg::STAT_PF];
    merged[exec_pkg::EFLAGS_CF] = st[exec_pkg::STAT_CF];
    return merged;
  endfunction

  // Move path, extending forms take the low byte
  always_comb begin
    if (ctl.sext) begin
      move_val = {{(DATA_W-8){opnd1[7]}}, opnd1[7:0]};
    end else if (ctl.zext) begin
      move_val = {{(DATA_W-8){1'b0}}, opnd1[7:0]};
    end else begin
      move_val = opnd1;
    end
  end

  // LAHF rewrites AH inside operand 0
  assign is_lahf  = (ctl.meta_cmd == exec_pkg::CMD_LAHF);
  assign lahf_val = {opnd0[DATA_W-1:16], meta_ah, opnd0[7:0]};

  always_comb begin
    result_d = opnd0;
    wr_en_d  = 1'b0;
    eflags_d = eflags_in;
    case (ctl.unit_sel)
      exec_pkg::UNIT_ALU: begin
        result_d = alu_result;
        wr_en_d  = !ctl.no_wr;
        eflags_d = merge_status(eflags_in, alu_status);
      end
      exec_pkg::UNIT_MOVE: begin
        result_d = move_val;
        wr_en_d  = 1'b1;
      end
      exec_pkg::UNIT_META: begin
        result_d = is_lahf ? lahf_val : opnd0;
        wr_en_d  = is_lahf;
        eflags_d = merge_status(eflags_in, meta_status);
        eflags_d[exec_pkg::EFLAGS_DF] = meta_df;
      end
      // NOP and illegal codes keep EFLAGS
      default: ;
    endcase
  end

  // Output stage, loaded only on a strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      wr_en      <= 1'b0;
      illegal    <= 1'b0;
      result     <= '0;
      eflags_out <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        wr_en      <= wr_en_d;
        illegal    <= ctl.illegal;
        result     <= result_d;
        eflags_out <= eflags_d;
      end
    end
  end

  // Decode and writeback agree on illegal opcodes
  assert property (@(posedge clk) disable iff (!rst_n) (out_valid && illegal) |-> !wr_en)
    else $error("wr_en set for an illegal opcode");

endmodule

// ==== exec_top.sv ====
module exec_top #(
  parameter int DATA_W = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  exec_pkg::cmd_e     opc,
  input  exec_pkg::word_t    eflags,
  input  logic [DATA_W-1:0]  opnd0,
  input  logic [DATA_W-1:0]  opnd1,
  output logic               out_valid,
  output logic               wr_en,
  output logic               illegal,
  output logic [DATA_W-1:0]  result,
  output exec_pkg::word_t    eflags_out
);

  exec_pkg::status_t status_in;
  exec_pkg::status_t alu_status;
  exec_pkg::status_t meta_status;
  logic [DATA_W-1:0] alu_result;
  exec_pkg::byte_t   meta_ah;
  logic              meta_df;

  // Arithmetic flags out of EFLAGS
  assign status_in[exec_pkg::STAT_OF] = eflags[exec_pkg::EFLAGS_OF];
  assign status_in[exec_pkg::STAT_SF] = eflags[exec_pkg::EFLAGS_SF];
  assign status_in[exec_pkg::STAT_ZF] = eflags[exec_pkg::EFLAGS_ZF];
  assign status_in[exec_pkg::STAT_PF] = eflags[exec_pkg::EFLAGS_PF];
  assign status_in[exec_pkg::STAT_CF] = eflags[exec_pkg::EFLAGS_CF];
  assign status_in[exec_pkg::STAT_AF] = eflags[exec_pkg::EFLAGS_AF];

  exec_ctrl_if ctl_if ();

  exec_decode decode_i (
    .opc (opc),
    .ctl (ctl_if.ctrl)
  );

  exec_alu #(
    .DATA_W (DATA_W)
  ) alu_i (
    .ctl        (ctl_if.unit),
    .status_in  (status_in),
    .opnd0      (opnd0),
    .opnd1      (opnd1),
    .result     (alu_result),
    .status_out (alu_status)
  );

  // AH is bits 15:8 of operand 0
  exec_meta meta_i (
    .ctl        (ctl_if.unit),
    .status_in  (status_in),
    .df_in      (eflags[exec_pkg::EFLAGS_DF]),
    .ah_in      (opnd0[15:8]),
    .ah_out     (meta_ah),
    .status_out (meta_status),
    .df_out     (meta_df)
  );

  exec_commit #(
    .DATA_W (DATA_W)
  ) commit_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .ctl         (ctl_if.commit),
    .eflags_in   (eflags),
    .opnd0       (opnd0),
    .opnd1       (opnd1),
    .alu_result  (alu_result),
    .alu_status  (alu_status),
    .meta_ah     (meta_ah),
    .meta_status (meta_status),
    .meta_df     (meta_df),
    .out_valid   (out_valid),
    .wr_en       (wr_en),
    .illegal     (illegal),
    .result      (result),
    .eflags_out  (eflags_out)
  );

endmodule

// ==== tb_exec.sv ====
module tb_exec;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ITEMS    = 2000;
  localparam int WAIT_LIMIT = 20;

  // Expected response of one item
  typedef struct packed {
    logic            illegal;
    logic            wr_en;
    exec_pkg::word_t result;
    exec_pkg::word_t eflags;
  } expect_t;

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  exec_pkg::cmd_e  opc;
  exec_pkg::word_t eflags;
  exec_pkg::word_t opnd0;
  exec_pkg::word_t opnd1;
  logic            out_valid;
  logic            wr_en;
  logic            illegal;
  exec_pkg::word_t result;
  exec_pkg::word_t eflags_out;

  expect_t exp_q;
  int      seen_count = 0;
  int      item;
  int      drain_cycles;

  exec_top exec_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .opc        (opc),
    .eflags     (eflags),
    .opnd0      (opnd0),
    .opnd1      (opnd1),
    .out_valid  (out_valid),
    .wr_en      (wr_en),
    .illegal    (illegal),
    .result     (result),
    .eflags_out (eflags_out)
  );

  always #5 clk = ~clk;

  // x86 rules for one item, written from the instruction set
  function automatic expect_t model_exec(logic [5:0] code, exec_pkg::word_t a,
                                         exec_pkg::word_t b, exec_pkg::word_t ef);
    expect_t         e;
    logic [32:0]     wide;
    exec_pkg::word_t r;
    logic            cin;
    logic            is_add;
    logic            is_sub;
    logic            is_logic;
    logic            keep_cf;
    e.illegal = 1'b0;
    e.wr_en   = 1'b0;
    e.result  = a;
    e.eflags  = ef;
    cin       = 1'b0;
    is_add    = 1'b0;
    is_sub    = 1'b0;
    is_logic  = 1'b0;
    keep_cf   = 1'b0;
    r         = '0;
    case (code)
      exec_pkg::CMD_NOP: ;
      exec_pkg::CMD_ADD: is_add = 1'b1;
      exec_pkg::CMD_ADC: begin
        is_add = 1'b1;
        cin    = ef[exec_pkg::EFLAGS_CF];
      end
      exec_pkg::CMD_INC: begin
        is_add  = 1'b1;
        b       = 32'd1;
        keep_cf = 1'b1;
      end
      exec_pkg::CMD_SUB, exec_pkg::CMD_CMP: is_sub = 1'b1;
      exec_pkg::CMD_SBB: begin
        is_sub = 1'b1;
        cin    = ef[exec_pkg::EFLAGS_CF];
      end
      exec_pkg::CMD_DEC: begin
        is_sub  = 1'b1;
        b       = 32'd1;
        keep_cf = 1'b1;
      end
      exec_pkg::CMD_AND, exec_pkg::CMD_TEST: begin
        is_logic = 1'b1;
        r        = a & b;
      end
      exec_pkg::CMD_OR: begin
        is_logic = 1'b1;
        r        = a | b;
      end
      exec_pkg::CMD_XOR: begin
        is_logic = 1'b1;
        r        = a ^ b;
      end
      exec_pkg::CMD_NOT: begin
        e.result = ~a;
        e.wr_en  = 1'b1;
      end
      exec_pkg::CMD_MOV, exec_pkg::CMD_LEA, exec_pkg::CMD_XCHG: begin
        e.result = b;
        e.wr_en  = 1'b1;
      end
      exec_pkg::CMD_MOVSX: begin
        e.result = {{24{b[7]}}, b[7:0]};
        e.wr_en  = 1'b1;
      end
      exec_pkg::CMD_MOVZX: begin
        e.result = {24'd0, b[7:0]};
        e.wr_en  = 1'b1;
      end
      exec_pkg::CMD_STC: e.eflags[exec_pkg::EFLAGS_CF] = 1'b1;
      exec_pkg::CMD_CLC: e.eflags[exec_pkg::EFLAGS_CF] = 1'b0;
      exec_pkg::CMD_STD: e.eflags[exec_pkg::EFLAGS_DF] = 1'b1;
      exec_pkg::CMD_CLD: e.eflags[exec_pkg::EFLAGS_DF] = 1'b0;
      // AH = SF ZF 0 AF 0 PF 1 CF
      exec_pkg::CMD_LAHF: begin
        e.result[15:8] = {ef[7], ef[6], 1'b0, ef[4], 1'b0, ef[2], 1'b1, ef[0]};
        e.wr_en        = 1'b1;
      end
      exec_pkg::CMD_SAHF: begin
        e.eflags[7] = a[15];
        e.eflags[6] = a[14];
        e.eflags[4] = a[12];
        e.eflags[2] = a[10];
        e.eflags[0] = a[8];
      end
      default: e.illegal = 1'b1;
    endcase
    if (is_add || is_sub) begin
      if (is_add) begin
        wide = {1'b0, a} + {1'b0, b} + {32'd0, cin};
      end else begin
        // Bit 32 is the borrow
        wide = {1'b0, a} - {1'b0, b} - {32'd0, cin};
      end
      r = wide[31:0];
      if (!keep_cf) begin
        e.eflags[exec_pkg::EFLAGS_CF] = wide[32];
      end
      if (is_add) begin
        e.eflags[exec_pkg::EFLAGS_OF] = (a[31] == b[31]) && (r[31] != a[31]);
      end else begin
        e.eflags[exec_pkg::EFLAGS_OF] = (a[31] != b[31]) && (r[31] != a[31]);
      end
      e.eflags[exec_pkg::EFLAGS_AF] = a[4] ^ b[4] ^ r[4];
      e.wr_en  = (code != exec_pkg::CMD_CMP);
    end
    if (is_logic) begin
      e.eflags[exec_pkg::EFLAGS_CF] = 1'b0;
      e.eflags[exec_pkg::EFLAGS_OF] = 1'b0;
      e.wr_en = (code != exec_pkg::CMD_TEST);
    end
    if (is_add || is_sub || is_logic) begin
      e.result = r;
      e.eflags[exec_pkg::EFLAGS_ZF] = (r == '0);
      e.eflags[exec_pkg::EFLAGS_SF] = r[31];
      e.eflags[exec_pkg::EFLAGS_PF] = ~^r[7:0];
    end
    return e;
  endfunction

  // Corner values now and then, to reach OF, ZF and carries
  function automatic exec_pkg::word_t pick_operand();
    case ($urandom_range(0, 7))
      0: return 32'h0000_0000;
      1: return 32'hffff_ffff;
      2: return 32'h8000_0000;
      3: return 32'h7fff_ffff;
      default: return $urandom;
    endcase
  endfunction

  task automatic report_mismatch(string name, exec_pkg::word_t got, exec_pkg::word_t want);
    $display("FAILED %s: got %h expected %h", name, got, want);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // One item on the strobe, mostly legal opcodes
  task automatic drive_item();
    logic [5:0] code;
    if ($urandom_range(0, 7) == 0) begin
      code = 6'($urandom_range(24, 63));
    end else begin
      code = 6'($urandom_range(0, 23));
    end
    in_valid <= 1'b1;
    opc      <= exec_pkg::cmd_e'(code);
    opnd0    <= pick_operand();
    opnd1    <= pick_operand();
    eflags   <= $urandom;
  endtask

  task automatic wait_for_output();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!out_valid && cycles < WAIT_LIMIT);
    if (!out_valid) begin
      report_failure("Timeout waiting for out_valid");
    end
  endtask

  // One-deep expectation, loaded with the strobe
  always @(posedge clk) begin
    if (rst_n && in_valid) begin
      exp_q <= model_exec(opc, opnd0, opnd1, eflags);
    end
    if (rst_n && out_valid) begin
      seen_count <= seen_count + 1;
    end
  end

  // Reset values
  assert property (@(posedge clk) !rst_n |=> (!out_valid && !wr_en && !illegal &&
                                             result == '0 && eflags_out == '0))
    else report_failure("Outputs not cleared by reset");

  // Strobe timing
  assert property (@(posedge clk) disable iff (!rst_n) in_valid |=> out_valid)
    else report_failure("out_valid missing one cycle after in_valid");
  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> $past(in_valid))
    else report_failure("out_valid high without in_valid one cycle earlier");

  // Output values
  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> result == exp_q.result)
    else report_mismatch("result", $sampled(result), $sampled(exp_q.result));
  assert property (@(posedge clk) disable iff (!rst_n)
                   out_valid |-> eflags_out == exp_q.eflags)
    else report_mismatch("eflags_out", $sampled(eflags_out), $sampled(exp_q.eflags));
  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> wr_en == exp_q.wr_en)
    else report_mismatch("wr_en", 32'($sampled(wr_en)), 32'($sampled(exp_q.wr_en)));
  assert property (@(posedge clk) disable iff (!rst_n)
                   out_valid |-> illegal == exp_q.illegal)
    else report_mismatch("illegal", 32'($sampled(illegal)), 32'($sampled(exp_q.illegal)));

  initial begin
    void'($urandom(32'h60bd));
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    opc      = exec_pkg::CMD_NOP;
    eflags   = '0;
    opnd0    = '0;
    opnd1    = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    for (item = 0; item < N_ITEMS; item++) begin
      @(posedge clk);
      drive_item();
      // Back to back or with an idle gap
      if ($urandom_range(0, 1) == 0) begin
        @(posedge clk);
        in_valid <= 1'b0;
        wait_for_output();
        repeat ($urandom_range(0, 3)) @(posedge clk);
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;

    // Drain the last results
    drain_cycles = 0;
    while (seen_count != N_ITEMS && drain_cycles < WAIT_LIMIT) begin
      @(posedge clk);
      drain_cycles++;
    end

    if (seen_count == N_ITEMS) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Only %0d of %0d results returned", seen_count, N_ITEMS);
      $display("Testbench failed");
      $fatal(1);
    end
  end

endmodule

// ==== tb.f ====
exec_pkg.sv
exec_ctrl_if.sv
exec_decode.sv
exec_alu.sv
exec_meta.sv
exec_commit.sv
exec_top.sv
tb_exec.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert --top-module tb_exec -f tb.f -o tb_exec_sim
./obj_dir/tb_exec_sim 2>&1 | tee sim.log
if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
exit 1
